// File: Makefile
VERILATOR ?= verilator
TOP       ?= middle_end_tb
FLIST     ?= middle_end.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/arith_pipe.sv
`include "middle_end_macros.svh"

module arith_pipe (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  middle_end_pkg::renamed_op_t op,
    input  logic [`DATA_W-1:0]          a,
    input  logic [`DATA_W-1:0]          b,
    input  logic [`DATA_W-1:0]          flags,
    output middle_end_pkg::cmplt_t      cmplt,
    output middle_end_pkg::cmplt_t      flags_cmplt
);
    import middle_end_pkg::*;

    logic               s1_valid;
    renamed_op_t        s1_op;
    logic [`DATA_W-1:0] s1_a;
    logic [`DATA_W-1:0] s1_b;
    logic               s1_cin;

    logic [`DATA_W:0]   wide;
    logic [`DATA_W-1:0] res;
    logic               carry;
    logic [`DATA_W-1:0] flag_byte;

    logic               s2_valid;
    renamed_op_t        s2_op;
    logic [`DATA_W-1:0] s2_res;
    logic [`DATA_W-1:0] s2_flags;

    // ########################################
    // Stage 1: operand capture
    // ########################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            s1_op  <= op;
            s1_a   <= a;
            s1_b   <= b;
            s1_cin <= flags[`FLAG_C];
        end
    end

    // ########################################
    // Stage 2: execute and result register
    // ########################################
    always_comb begin
        wide  = '0;
        res   = '0;
        carry = 1'b0;
        case (s1_op.opcode)
            OP_ADD: begin
                wide  = {1'b0, s1_a} + {1'b0, s1_b} + {{`DATA_W{1'b0}}, s1_cin};
                res   = wide[`DATA_W-1:0];
                carry = wide[`DATA_W];
            end
            OP_SUB: begin
                // Carry doubles as borrow
                wide  = {1'b0, s1_a} - {1'b0, s1_b};
                res   = wide[`DATA_W-1:0];
                carry = wide[`DATA_W];
            end
            OP_AND: res = s1_a & s1_b;
            OP_OR:  res = s1_a | s1_b;
            OP_XOR: res = s1_a ^ s1_b;
            OP_SHL: begin
                wide  = {1'b0, s1_a} << s1_b[2:0];
                res   = wide[`DATA_W-1:0];
                carry = wide[`DATA_W];
            end
            OP_SHR: begin
                wide  = {s1_a, 1'b0} >> s1_b[2:0];
                res   = wide[`DATA_W:1];
                carry = wide[0];
            end
            default: res = s1_a;
        endcase
    end

    always_comb begin
        flag_byte = '0;
        flag_byte[`FLAG_Z] = (res == '0);
        flag_byte[`FLAG_C] = carry;
        flag_byte[`FLAG_N] = res[`DATA_W-1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_op    <= s1_op;
            s2_res   <= res;
            s2_flags <= flag_byte;
        end
    end

    assign cmplt = '{s2_valid, s2_op.rob_entry, s2_op.dest_reg, s2_op.arch_dest, s2_res};
    assign flags_cmplt = '{s2_valid, s2_op.rob_entry, s2_op.operands.alu.flag_dest,
                           s2_op.arch_dest, s2_flags};

endmodule

// File: design/issue_ctrl.sv
`include "middle_end_macros.svh"

module issue_ctrl (
    input  middle_end_pkg::renamed_op_t [2:0]             slot_op,
    input  logic [2:0]                                    slot_valid,
    input  middle_end_pkg::reg_write_t [`CMPLT_PORTS-1:0] reg_wr,
    output logic [`RD_PORTS-1:0][`PREG_W-1:0]             rd_addr,
    input  logic [`RD_PORTS-1:0][`DATA_W-1:0]             rd_data,
    output logic                                          alu_start,
    output logic                                          mem_start,
    output logic                                          term_start,
    output logic [2:0][`DATA_W-1:0]                       alu_opnd,
    output logic [2:0][`DATA_W-1:0]                       mem_opnd,
    output logic [2:0][`DATA_W-1:0]                       term_opnd
);
    import middle_end_pkg::*;

    logic [`RD_PORTS-1:0][`DATA_W-1:0] fwd_data;

    // Slot 0 reads the ALU view, slots 1 and 2 the control view
    always_comb begin
        rd_addr[0] = slot_op[0].operands.alu.src_a;
        rd_addr[1] = slot_op[0].operands.alu.src_b;
        rd_addr[2] = slot_op[0].operands.alu.flags_src;
        for (int s = 1; s < 3; s++) begin
            rd_addr[3*s]     = slot_op[s].operands.ctl.src_a;
            rd_addr[3*s + 1] = slot_op[s].operands.ctl.src_b;
            rd_addr[3*s + 2] = slot_op[s].operands.ctl.src_c;
        end
    end

    // Completion bypass where the newest write wins
    always_comb begin
        for (int r = 0; r < `RD_PORTS; r++) begin
            fwd_data[r] = rd_data[r];
            for (int p = 0; p < `CMPLT_PORTS; p++) begin
                if (reg_wr[p].valid && reg_wr[p].dest_reg == rd_addr[r]) begin
                    fwd_data[r] = reg_wr[p].data;
                end
            end
        end
    end

    // Wrong-pipe opcodes are dropped here
    assign alu_start  = slot_valid[0] && (slot_op[0].opcode inside
                        {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_PASS});
    assign mem_start  = slot_valid[1] && (slot_op[1].opcode inside {OP_LOAD, OP_STORE});
    assign term_start = slot_valid[2] && slot_op[2].opcode == OP_BRANCH;

    assign alu_opnd  = fwd_data[2:0];
    assign mem_opnd  = fwd_data[5:3];
    assign term_opnd = fwd_data[8:6];

endmodule

// File: design/mem_pipe.sv
`include "middle_end_macros.svh"

module mem_pipe (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  middle_end_pkg::renamed_op_t op,
    input  logic [`DATA_W-1:0]          base_hi,
    input  logic [`DATA_W-1:0]          base_lo,
    input  logic [`DATA_W-1:0]          store_data,
    output logic [`ADDR_W-1:0]          mem_addr,
    output logic                        mem_store,
    output logic [`DATA_W-1:0]          mem_dout,
    input  logic [`DATA_W-1:0]          mem_din,
    output middle_end_pkg::cmplt_t      cmplt
);
    import middle_end_pkg::*;

    logic [`ADDR_W-1:0] addr_calc;
    logic               is_load;
    logic               is_store;

    logic               s1_load;
    renamed_op_t        s1_op;
    logic               s2_load;
    renamed_op_t        s2_op;

    assign addr_calc = {base_hi, base_lo}
                     + {{(`ADDR_W-`IMM_W){1'b0}}, op.operands.ctl.imm};
    assign is_load   = start && op.opcode == OP_LOAD;
    assign is_store  = start && op.opcode == OP_STORE;

    // ########################################
    // Access issue
    // ########################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_store <= 1'b0;
            s1_load   <= 1'b0;
            s2_load   <= 1'b0;
        end else begin
            mem_store <= is_store;
            s1_load   <= is_load;
            s2_load   <= s1_load;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mem_addr <= addr_calc;
            mem_dout <= store_data;
            s1_op    <= op;
        end
        if (s1_load) begin
            s2_op <= s1_op;
        end
    end

    // Load data arrives one cycle after the address
    assign cmplt = '{s2_load, s2_op.rob_entry, s2_op.dest_reg, s2_op.arch_dest, mem_din};

endmodule

// File: design/middle_end.sv
`include "middle_end_macros.svh"

module middle_end (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  middle_end_pkg::renamed_op_t [2:0]             slot_op,
    input  logic [2:0]                                    slot_valid,
    input  middle_end_pkg::reg_write_t [`CMPLT_PORTS-1:0] reg_wr,
    input  logic [`DATA_W-1:0]                            mem_din,
    output middle_end_pkg::cmplt_t                        arith_cmplt,
    output middle_end_pkg::cmplt_t                        arith_flags,
    output middle_end_pkg::cmplt_t                        mem_cmplt,
    output middle_end_pkg::branch_t                       branch_out,
    output logic [`ADDR_W-1:0]                            mem_addr,
    output logic                                          mem_store,
    output logic [`DATA_W-1:0]                            mem_dout
);

    logic [`RD_PORTS-1:0][`PREG_W-1:0] rd_addr;
    logic [`RD_PORTS-1:0][`DATA_W-1:0] rd_data;
    logic                              alu_start;
    logic                              mem_start;
    logic                              term_start;
    logic [2:0][`DATA_W-1:0]           alu_opnd;
    logic [2:0][`DATA_W-1:0]           mem_opnd;
    logic [2:0][`DATA_W-1:0]           term_opnd;

    phys_reg_file prf_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .reg_wr  (reg_wr)
    );

    issue_ctrl ctrl_i (
        .slot_op    (slot_op),
        .slot_valid (slot_valid),
        .reg_wr     (reg_wr),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .alu_start  (alu_start),
        .mem_start  (mem_start),
        .term_start (term_start),
        .alu_opnd   (alu_opnd),
        .mem_opnd   (mem_opnd),
        .term_opnd  (term_opnd)
    );

    // ########################################
    // Execution pipes
    // ########################################
    arith_pipe arith_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (alu_start),
        .op          (slot_op[0]),
        .a           (alu_opnd[0]),
        .b           (alu_opnd[1]),
        .flags       (alu_opnd[2]),
        .cmplt       (arith_cmplt),
        .flags_cmplt (arith_flags)
    );

    mem_pipe mem_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (mem_start),
        .op         (slot_op[1]),
        .base_hi    (mem_opnd[0]),
        .base_lo    (mem_opnd[1]),
        .store_data (mem_opnd[2]),
        .mem_addr   (mem_addr),
        .mem_store  (mem_store),
        .mem_dout   (mem_dout),
        .mem_din    (mem_din),
        .cmplt      (mem_cmplt)
    );

    term_pipe term_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (term_start),
        .op     (slot_op[2]),
        .tgt_hi (term_opnd[0]),
        .tgt_lo (term_opnd[1]),
        .flags  (term_opnd[2]),
        .branch (branch_out)
    );

endmodule

// File: design/middle_end_pkg.sv
`include "middle_end_macros.svh"

package middle_end_pkg;

    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_AND    = 4'd2,
        OP_OR     = 4'd3,
        OP_XOR    = 4'd4,
        OP_SHL    = 4'd5,
        OP_SHR    = 4'd6,
        OP_PASS   = 4'd7,
        OP_LOAD   = 4'd8,
        OP_STORE  = 4'd9,
        OP_BRANCH = 4'd10
    } opcode_e;

    // Arithmetic slot view
    typedef struct packed {
        logic [`PREG_W-1:0] src_a;
        logic [`PREG_W-1:0] src_b;
        logic [`PREG_W-1:0] flags_src;
        logic [`PREG_W-1:0] flag_dest;
    } alu_operands_t;

    // Memory and terminate slot view
    typedef struct packed {
        logic [`PREG_W-1:0] src_a;
        logic [`PREG_W-1:0] src_b;
        logic [`PREG_W-1:0] src_c;
        logic [`IMM_W-1:0]  imm;
        logic               spare;
    } ctl_operands_t;

    typedef union packed {
        alu_operands_t alu;
        ctl_operands_t ctl;
    } operands_u;

    typedef struct packed {
        opcode_e            opcode;
        logic [`ROB_W-1:0]  rob_entry;
        logic [`PREG_W-1:0] dest_reg;
        logic [`AREG_W-1:0] arch_dest;
        operands_u          operands;
    } renamed_op_t;

    typedef struct packed {
        logic               valid;
        logic [`ROB_W-1:0]  rob_entry;
        logic [`PREG_W-1:0] dest_reg;
        logic [`AREG_W-1:0] arch_dest;
        logic [`DATA_W-1:0] data;
    } cmplt_t;

    typedef struct packed {
        logic               valid;
        logic [`PREG_W-1:0] dest_reg;
        logic [`DATA_W-1:0] data;
    } reg_write_t;

    typedef struct packed {
        logic               valid;
        logic [`ROB_W-1:0]  rob_entry;
        logic [`ADDR_W-1:0] target;
    } branch_t;

endpackage

// File: design/phys_reg_file.sv
`include "middle_end_macros.svh"

module phys_reg_file (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [`RD_PORTS-1:0][`PREG_W-1:0]       rd_addr,
    output logic [`RD_PORTS-1:0][`DATA_W-1:0]       rd_data,
    input  middle_end_pkg::reg_write_t [`CMPLT_PORTS-1:0] reg_wr
);

    logic [`DATA_W-1:0] regs [`PREG_NUM];

    // ########################################
    // Write ports
    // ########################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PREG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // Later port lands last, so it wins a clash
            for (int p = 0; p < `CMPLT_PORTS; p++) begin
                if (reg_wr[p].valid) begin
                    regs[reg_wr[p].dest_reg] <= reg_wr[p].data;
                end
            end
        end
    end

    // ########################################
    // Read ports
    // ########################################
    always_comb begin
        for (int r = 0; r < `RD_PORTS; r++) begin
            rd_data[r] = regs[rd_addr[r]];
        end
    end

endmodule

// File: design/term_pipe.sv
`include "middle_end_macros.svh"

module term_pipe (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  middle_end_pkg::renamed_op_t op,
    input  logic [`DATA_W-1:0]          tgt_hi,
    input  logic [`DATA_W-1:0]          tgt_lo,
    input  logic [`DATA_W-1:0]          flags,
    output middle_end_pkg::branch_t     branch
);
    import middle_end_pkg::*;

    logic              taken;
    logic              br_valid;
    logic [`ROB_W-1:0] br_rob;
    logic [`ADDR_W-1:0] br_target;

    // Taken when any masked flag is set
    assign taken = start && op.opcode == OP_BRANCH
                && |(flags & {{(`DATA_W-`IMM_W){1'b0}}, op.operands.ctl.imm});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            br_valid <= 1'b0;
        end else begin
            br_valid <= taken;
        end
    end

    always_ff @(posedge clk) begin
        if (taken) begin
            br_rob    <= op.rob_entry;
            br_target <= {tgt_hi, tgt_lo};
        end
    end

    assign branch = '{br_valid, br_rob, br_target};

endmodule

// File: include/middle_end_macros.svh
`ifndef MIDDLE_END_MACROS_SVH
`define MIDDLE_END_MACROS_SVH

// Physical register file
`define PREG_NUM 32
`define PREG_W 5
`define DATA_W 8
`define RD_PORTS 9

// Tags and memory
`define ADDR_W 16
`define ROB_W 5
`define AREG_W 4
`define IMM_W 4

`define CMPLT_PORTS 2

// Bit positions in the flags byte
`define FLAG_Z 0
`define FLAG_C 1
`define FLAG_N 2

`endif

// File: middle_end.f
+incdir+include
design/middle_end_pkg.sv
design/phys_reg_file.sv
design/issue_ctrl.sv
design/arith_pipe.sv
design/mem_pipe.sv
design/term_pipe.sv
design/middle_end.sv
verif/middle_end_assertions.sv
verif/middle_end_tb.sv

// File: verif/middle_end_assertions.sv
module middle_end_assertions (
    input logic                              clk,
    input logic                              rst_n,
    input middle_end_pkg::renamed_op_t [2:0] slot_op,
    input logic [2:0]                        slot_valid,
    input logic                              alu_start,
    input logic                              mem_store,
    input middle_end_pkg::cmplt_t            arith_cmplt,
    input middle_end_pkg::cmplt_t            arith_flags,
    input middle_end_pkg::cmplt_t            mem_cmplt,
    input middle_end_pkg::branch_t           branch_out
);
    import middle_end_pkg::*;

    // Set once the first reset edge has cleared the flops
    logic rst_seen = 1'b0;
    int   fail_count = 0;

    always @(posedge clk) begin
        if (!rst_n) begin
            rst_seen <= 1'b1;
        end
    end

    // One store pulse per accepted store, back-to-back stores included
    store_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        mem_store == $past(slot_valid[1] && slot_op[1].opcode == OP_STORE))
        else begin
            $error("mem_store is not a single pulse one cycle after a store issue");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        (!rst_n && rst_seen) |-> !(arith_cmplt.valid || arith_flags.valid
                                  || mem_cmplt.valid || branch_out.valid || mem_store))
        else begin
            $error("valid output high during reset");
            fail_count++;
        end

    alu_latency: assert property (@(posedge clk) disable iff (!rst_n)
        arith_cmplt.valid == $past(alu_start, 2))
        else begin
            $error("arith completion not exactly two cycles after start");
            fail_count++;
        end

endmodule

bind middle_end middle_end_assertions asrt_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .slot_op     (slot_op),
    .slot_valid  (slot_valid),
    .alu_start   (alu_start),
    .mem_store   (mem_store),
    .arith_cmplt (arith_cmplt),
    .arith_flags (arith_flags),
    .mem_cmplt   (mem_cmplt),
    .branch_out  (branch_out)
);

// File: verif/middle_end_tb.sv
`include "middle_end_macros.svh"

module middle_end_tb;
    import middle_end_pkg::*;

    typedef struct packed {
        logic [31:0] due;
        cmplt_t      res;
        cmplt_t      flg;
    } alu_exp_t;

    typedef struct packed {
        logic [31:0]        due;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] data;
    } store_exp_t;

    typedef struct packed {
        logic [31:0] due;
        cmplt_t      res;
    } load_exp_t;

    typedef struct packed {
        logic [31:0] due;
        branch_t     br;
    } branch_exp_t;

    localparam int TEST_CYCLES = 49 + 150 + 40 + 80 + 100 + 400;
    localparam int MARGIN      = 200;

    logic                               clk = 1'b0;
    logic                               rst_n;
    renamed_op_t [2:0]                  slot_op;
    logic [2:0]                         slot_valid;
    reg_write_t [`CMPLT_PORTS-1:0]      reg_wr;
    logic [`DATA_W-1:0]                 mem_din = '0;
    cmplt_t                             arith_cmplt;
    cmplt_t                             arith_flags;
    cmplt_t                             mem_cmplt;
    branch_t                            branch_out;
    logic [`ADDR_W-1:0]                 mem_addr;
    logic                               mem_store;
    logic [`DATA_W-1:0]                 mem_dout;

    logic [`DATA_W-1:0] shadow [`PREG_NUM];
    logic [`DATA_W-1:0] mem [65536];
    logic [`DATA_W-1:0] ref_mem [65536];
    logic [31:0]        lfsr = 32'hc327;
    int                 cyc = 0;
    int                 errors = 0;
    int                 err_mark = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;

    alu_exp_t    aq[$];
    store_exp_t  sq[$];
    load_exp_t   lq[$];
    branch_exp_t bq[$];
    renamed_op_t st_ops[$];

    middle_end dut_i (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ########################################
    // Memory model with one cycle read latency
    // ########################################
    always @(posedge clk) begin
        mem_din <= mem[mem_addr];
        if (mem_store) begin
            mem[mem_addr] <= mem_dout;
        end
    end

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic renamed_op_t rand_op(int slot, bit mix);
        renamed_op_t o;
        o.rob_entry = `ROB_W'(rand_bits(`ROB_W));
        o.dest_reg  = `PREG_W'(rand_bits(`PREG_W));
        o.arch_dest = `AREG_W'(rand_bits(`AREG_W));
        o.operands  = 20'(rand_bits(20));
        if (mix && rand_bits(3) == 0) begin
            o.opcode = opcode_e'(4'(rand_bits(4)));
        end else if (slot == 0) begin
            o.opcode = opcode_e'(4'(rand_bits(3)));
        end else if (slot == 1) begin
            o.opcode = rand_bits(1) ? OP_STORE : OP_LOAD;
        end else begin
            o.opcode = OP_BRANCH;
        end
        return o;
    endfunction

    // Register value as an issue sees it including same-cycle writes
    function automatic logic [`DATA_W-1:0] opnd(logic [`PREG_W-1:0] r);
        logic [`DATA_W-1:0] v;
        v = shadow[r];
        for (int p = 0; p < `CMPLT_PORTS; p++) begin
            if (reg_wr[p].valid && reg_wr[p].dest_reg == r) begin
                v = reg_wr[p].data;
            end
        end
        return v;
    endfunction

    // Returns {flags, result}
    function automatic logic [15:0] alu_ref(opcode_e opc, logic [7:0] a, logic [7:0] b,
                                            logic [7:0] fl);
        int         sum;
        int         s;
        logic [7:0] r;
        logic       c;
        c = 1'b0;
        s = b % 8;
        case (opc)
            OP_ADD: begin
                sum = a + b + fl[`FLAG_C];
                r   = sum[7:0];
                c   = sum > 255;
            end
            OP_SUB: begin
                r = a - b;
                c = a < b;
            end
            OP_AND: r = a & b;
            OP_OR:  r = a | b;
            OP_XOR: r = a ^ b;
            OP_SHL: begin
                r = a << s;
                c = (s != 0) && a[8-s];
            end
            OP_SHR: begin
                r = a >> s;
                c = (s != 0) && a[s-1];
            end
            default: r = a;
        endcase
        return {5'b0, r[7], c, r == 8'h00, r};
    endfunction

    task automatic book();
        renamed_op_t        o;
        logic [15:0]        ar;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] c;
        o = slot_op[0];
        if (slot_valid[0] && o.opcode <= OP_PASS) begin
            ar = alu_ref(o.opcode, opnd(o.operands.alu.src_a), opnd(o.operands.alu.src_b),
                         opnd(o.operands.alu.flags_src));
            aq.push_back('{cyc + 2,
                '{1'b1, o.rob_entry, o.dest_reg, o.arch_dest, ar[7:0]},
                '{1'b1, o.rob_entry, o.operands.alu.flag_dest, o.arch_dest, ar[15:8]}});
        end
        o = slot_op[1];
        if (slot_valid[1] && (o.opcode == OP_LOAD || o.opcode == OP_STORE)) begin
            addr = {opnd(o.operands.ctl.src_a), opnd(o.operands.ctl.src_b)}
                 + o.operands.ctl.imm;
            if (o.opcode == OP_STORE) begin
                c = opnd(o.operands.ctl.src_c);
                sq.push_back('{cyc + 1, addr, c});
                ref_mem[addr] = c;
            end else begin
                lq.push_back('{cyc + 2,
                    '{1'b1, o.rob_entry, o.dest_reg, o.arch_dest, ref_mem[addr]}});
            end
        end
        o = slot_op[2];
        if (slot_valid[2] && o.opcode == OP_BRANCH
                && (opnd(o.operands.ctl.src_c) & {4'b0, o.operands.ctl.imm}) != 0) begin
            bq.push_back('{cyc + 1, '{1'b1, o.rob_entry,
                {opnd(o.operands.ctl.src_a), opnd(o.operands.ctl.src_b)}}});
        end
        for (int p = 0; p < `CMPLT_PORTS; p++) begin
            if (reg_wr[p].valid) begin
                shadow[reg_wr[p].dest_reg] = reg_wr[p].data;
            end
        end
    endtask

    task automatic step();
        book();
        @(negedge clk);
    endtask

    task automatic idle();
        slot_valid = '0;
        reg_wr     = '0;
        step();
    endtask

    task automatic drain();
        while (aq.size() + sq.size() + lq.size() + bq.size() > 0) begin
            idle();
        end
        idle();
    endtask

    task automatic fail_check(string msg);
        $display("error %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(string name);
        drain();
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
        end
        $display("test %s: %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // ########################################
    // Comparator
    // ########################################
    always @(negedge clk) begin
        if (rst_n) begin
            if (aq.size() > 0 && aq[0].due == cyc) begin
                assert (arith_cmplt == aq[0].res && arith_flags == aq[0].flg)
                else fail_check($sformatf("arith got %h/%h, expected %h/%h",
                                arith_cmplt, arith_flags, aq[0].res, aq[0].flg));
                void'(aq.pop_front());
            end else begin
                assert (!arith_cmplt.valid && !arith_flags.valid)
                else fail_check("unexpected arith completion");
            end
            if (sq.size() > 0 && sq[0].due == cyc) begin
                assert (mem_store && mem_addr == sq[0].addr && mem_dout == sq[0].data)
                else fail_check($sformatf("store got %b %h %h, expected %h %h",
                                mem_store, mem_addr, mem_dout, sq[0].addr, sq[0].data));
                void'(sq.pop_front());
            end else begin
                assert (!mem_store) else fail_check("unexpected mem_store");
            end
            if (lq.size() > 0 && lq[0].due == cyc) begin
                assert (mem_cmplt == lq[0].res)
                else fail_check($sformatf("load got %h, expected %h", mem_cmplt, lq[0].res));
                void'(lq.pop_front());
            end else begin
                assert (!mem_cmplt.valid) else fail_check("unexpected mem completion");
            end
            if (bq.size() > 0 && bq[0].due == cyc) begin
                assert (branch_out == bq[0].br)
                else fail_check($sformatf("branch got %h, expected %h", branch_out, bq[0].br));
                void'(bq.pop_front());
            end else begin
                assert (!branch_out.valid) else fail_check("unexpected branch output");
            end
        end
    end

    initial begin
        #((8 + TEST_CYCLES + MARGIN) * 100);
        $display("watchdog: the tests did not finish in the expected time");
        $display("RESULT: FAIL");
        $finish;
    end

    // ########################################
    // Tests
    // ########################################
    initial begin
        renamed_op_t o;
        rst_n      = 1'b0;
        slot_op    = '0;
        slot_valid = '0;
        reg_wr     = '0;
        for (int r = 0; r < `PREG_NUM; r++) begin
            shadow[r] = '0;
        end
        for (int a = 0; a < 65536; a++) begin
            mem[a]     = 8'(a >> 8) ^ 8'(a) ^ 8'h3c;
            ref_mem[a] = mem[a];
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        for (int r = 0; r < `PREG_NUM; r += 2) begin
            reg_wr[0] = '{1'b1, `PREG_W'(r), `DATA_W'(rand_bits(8))};
            reg_wr[1] = '{1'b1, `PREG_W'(r + 1), `DATA_W'(rand_bits(8))};
            step();
        end
        reg_wr[0] = '{1'b1, 5'd5, `DATA_W'(rand_bits(8))};
        reg_wr[1] = '{1'b1, 5'd5, `DATA_W'(rand_bits(8))};
        step();
        reg_wr = '0;
        for (int r = 0; r < `PREG_NUM; r++) begin
            o = rand_op(0, 1'b0);
            o.opcode = OP_PASS;
            o.operands.alu.src_a = `PREG_W'(r);
            slot_op[0]    = o;
            slot_valid[0] = 1'b1;
            step();
        end
        finish_test("register preload");

        for (int i = 0; i < 150; i++) begin
            slot_op[0]    = rand_op(0, 1'b0);
            slot_valid[0] = 1'b1;
            step();
        end
        finish_test("alu operations");

        for (int i = 0; i < 40; i++) begin
            o = rand_op(0, 1'b0);
            reg_wr[0]     = '{1'b1, o.operands.alu.src_a, `DATA_W'(rand_bits(8))};
            reg_wr[1]     = '{1'(rand_bits(1)), o.operands.alu.src_b, `DATA_W'(rand_bits(8))};
            slot_op[0]    = o;
            slot_valid[0] = 1'b1;
            step();
        end
        finish_test("completion bypass");

        for (int i = 0; i < 40; i++) begin
            o = rand_op(1, 1'b0);
            o.opcode = OP_STORE;
            st_ops.push_back(o);
            slot_op[1]    = o;
            slot_valid[1] = 1'b1;
            step();
        end
        foreach (st_ops[i]) begin
            o = st_ops[i];
            o.opcode = OP_LOAD;
            slot_op[1]    = o;
            slot_valid[1] = 1'b1;
            step();
        end
        finish_test("loads and stores");

        for (int i = 0; i < 100; i++) begin
            slot_op[2]    = rand_op(2, 1'b0);
            slot_valid[2] = 1'b1;
            step();
        end
        finish_test("branches");

        for (int i = 0; i < 400; i++) begin
            for (int s = 0; s < 3; s++) begin
                slot_op[s] = rand_op(s, 1'b1);
            end
            slot_valid = 3'b111;
            reg_wr[0]  = '{1'(rand_bits(1)), `PREG_W'(rand_bits(5)), `DATA_W'(rand_bits(8))};
            reg_wr[1]  = '{1'(rand_bits(1)), `PREG_W'(rand_bits(5)), `DATA_W'(rand_bits(8))};
            step();
        end
        finish_test("full throughput");

        // Bound assertion failures count as check errors
        errors += dut_i.asrt_i.fail_count;
        $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
